//--- sources.f
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/bus_decoder.sv
logic/word_ram.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/core_timer.sv
logic/soc_top.sv
test/soc_tb.sv

//--- Bender.yml
package:
  name: soc_periph

sources:
  - logic/soc_pkg.sv
  - logic/mem_bus_if.sv
  - logic/bus_decoder.sv
  - logic/word_ram.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/uart_regs.sv
  - logic/core_timer.sv
  - logic/soc_top.sv
  - target: test
    files:
      - test/soc_tb.sv

//--- test/soc_tb.sv
/*
 * self-checking testbench for the peripheral subsystem
 *   bus driver, address map and ram shadow reference, compare tasks
 *   ram, frequency/fault, uart loopback and timer sequences, watchdog
 */
module soc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import soc_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int BUS_TIMEOUT  = 2 * FRAME_CYCLES;
    localparam int POLL_LIMIT   = 4 * FRAME_CYCLES;
    // several times what the ram, uart and timer sequences take together
    localparam int WATCHDOG_CYCLES = 5000;

    logic  clk;
    logic  resetn;
    logic  bus_valid;
    addr_t bus_addr;
    data_t bus_wdata;
    strb_t bus_wstrb;
    data_t bus_rdata;
    logic  bus_ready;
    logic  fault;
    logic  timer_irq;
    logic  uart_line;

    // expected response of the request in flight
    data_t exp_rdata;
    logic  exp_fault;
    logic  exp_known;

    data_t       ram_shadow [RAM_WORDS];
    logic [31:0] rng_state   = 32'he91824d4;
    int          cycle_count = 0;
    int          checks      = 0;
    int          errors      = 0;

    soc_top dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .bus_valid  (bus_valid),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wstrb  (bus_wstrb),
        .bus_rdata  (bus_rdata),
        .bus_ready  (bus_ready),
        .fault      (fault),
        .timer_irq  (timer_irq),
        .uart_tx_out(uart_line),
        .uart_rx_in (uart_line)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic slave_sel_e classify_addr(input addr_t addr);
        if (addr < addr_t'(RAM_WORDS * 4)) begin
            return sel_ram;
        end
        if (addr == UART_TX_ADDR || addr == UART_RX_ADDR || addr == UART_LSR_ADDR) begin
            return sel_uart;
        end
        // four timer words from the base
        if (addr >= TIMER_BASE && addr < TIMER_BASE + 32'd16) begin
            return sel_timer;
        end
        if (addr == FREQ_ADDR) begin
            return sel_freq;
        end
        return sel_fault;
    endfunction

    // returns 1 when the read data of this access is predictable
    function automatic logic predict_access(input addr_t addr, input data_t wdata,
                                            input strb_t wstrb, output data_t rdata,
                                            output logic flt);
        ram_index_t idx;
        logic       known;
        idx   = addr[RAM_INDEX_W+1:2];
        rdata = '0;
        flt   = 1'b0;
        known = 1'b0;
        case (classify_addr(addr))
            sel_ram: begin
                if (wstrb == '0) begin
                    rdata = ram_shadow[idx];
                    known = 1'b1;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            ram_shadow[idx][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                end
            end
            sel_freq: begin
                rdata = SYS_CLK_HZ;
                known = 1'b1;
            end
            sel_fault: begin
                flt   = 1'b1;
                known = 1'b1;
            end
            default: known = 1'b0;
        endcase
        return known;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %t: %s is %h, expected %h", $realtime, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %t: %s is %b, expected %b", $realtime, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %t: %s is %h, expected %h", $realtime, name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("checks run: %0d, errors: %0d", checks, errors);
    endtask

    // every response is checked mid-cycle where ready and rdata are settled
    always @(negedge clk) begin
        if (resetn && bus_ready) begin
            check_flag("fault", fault, exp_fault);
            if (exp_known) begin
                check_data("bus_rdata", bus_rdata, exp_rdata);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bus driver called and returning on a falling edge

    task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                              output data_t rdata, output int waited);
        exp_known = predict_access(addr, wdata, wstrb, exp_rdata, exp_fault);
        bus_addr  = addr;
        bus_wdata = wdata;
        bus_wstrb = wstrb;
        bus_valid = 1'b1;
        waited    = 0;
        @(negedge clk);
        while (!bus_ready && waited < BUS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!bus_ready) begin
            errors++;
            $display("no bus response within %0d cycles for address %h", BUS_TIMEOUT, addr);
        end
        rdata = bus_rdata;
        // hold the request over the ready edge, then release
        @(negedge clk);
        bus_valid = 1'b0;
        bus_wstrb = '0;
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
        data_t unused;
        int    waited;
        bus_access(addr, wdata, wstrb, unused, waited);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        int waited;
        bus_access(addr, '0, '0, rdata, waited);
    endtask

    task automatic wait_lsr_bit(input int bit_idx, input logic value, input string what);
        data_t lsr;
        for (int i = 0; i < POLL_LIMIT; i++) begin
            bus_read(UART_LSR_ADDR, lsr);
            if (lsr[bit_idx] === value) begin
                return;
            end
        end
        errors++;
        $display("line status bit %0d never became %b while waiting for %s", bit_idx, value,
                 what);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        ram_index_t  picks [16];
        logic [31:0] r;
        data_t       rdata;
        data_t       first;
        data_t       mt_lo;
        data_t       mt_hi;
        logic [63:0] target;
        byte_t       tx_a;
        byte_t       tx_b;
        int          waited;
        int          t0;

        $timeformat(-9, 1, " ns", 10);
        clk       = 1'b0;
        resetn    = 1'b0;
        bus_valid = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_wstrb = '0;
        exp_rdata = '0;
        exp_fault = 1'b0;
        exp_known = 1'b0;
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // outputs at rest after reset
        check_flag("bus_ready after reset", bus_ready, 1'b0);
        check_flag("fault after reset", fault, 1'b0);
        check_flag("timer_irq after reset", timer_irq, 1'b0);
        check_flag("uart_tx_out after reset", uart_line, 1'b1);

        // ram gets full words and then partial strobes before the read back
        for (int i = 0; i < 16; i++) begin
            r        = xorshift32();
            picks[i] = r[RAM_INDEX_W-1:0];
            bus_write(addr_t'({picks[i], 2'b00}), xorshift32(), 4'hf);
        end
        for (int i = 0; i < 32; i++) begin
            r = xorshift32();
            bus_write(addr_t'({picks[r[3:0]], 2'b00}), xorshift32(), r[7:4]);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(addr_t'({picks[i], 2'b00}), rdata);
        end

        // frequency register and unmapped addresses
        bus_read(FREQ_ADDR, rdata);
        bus_read(32'h2000_0000, rdata);
        bus_read(32'h1000_000c, rdata);
        bus_write(addr_t'(RAM_WORDS * 4), 32'hdead_beef, 4'hf);

        // single byte through the loopback
        bus_write(UART_TX_ADDR, 32'h0000_00a5, 4'b0001);
        bus_read(UART_LSR_ADDR, rdata);
        check_flag("lsr tx idle while sending", rdata[5], 1'b0);
        wait_lsr_bit(0, 1'b1, "the looped back byte");
        bus_read(UART_RX_ADDR, rdata);
        check_byte("rx byte", rdata[7:0], 8'ha5);
        bus_read(UART_LSR_ADDR, rdata);
        check_flag("lsr byte waiting after rx read", rdata[0], 1'b0);

        // second of two back-to-back writes is held off by the transmitter
        wait_lsr_bit(5, 1'b1, "the transmitter to go idle");
        r    = xorshift32();
        tx_a = r[7:0];
        tx_b = r[15:8];
        bus_access(UART_TX_ADDR, data_t'(tx_a), 4'b0001, rdata, waited);
        bus_access(UART_TX_ADDR, data_t'(tx_b), 4'b0001, rdata, waited);
        check_flag("second tx write held off", waited >= 9 * CLKS_PER_BIT, 1'b1);
        wait_lsr_bit(0, 1'b1, "the first of two bytes");
        bus_read(UART_RX_ADDR, rdata);
        check_byte("rx first byte", rdata[7:0], tx_a);
        wait_lsr_bit(0, 1'b1, "the second of two bytes");
        bus_read(UART_RX_ADDR, rdata);
        check_byte("rx second byte", rdata[7:0], tx_b);

        // timer counts up and raises the interrupt at mtimecmp
        bus_read(TIMER_BASE, first);
        bus_read(TIMER_BASE, rdata);
        check_flag("mtime low non-decreasing", rdata >= first, 1'b1);
        bus_read(TIMER_BASE + 32'd4, mt_hi);
        bus_read(TIMER_BASE, mt_lo);
        t0     = cycle_count;
        target = {mt_hi, mt_lo} + 64'd50;
        bus_write(TIMER_BASE + 32'd8, target[31:0], 4'hf);
        bus_write(TIMER_BASE + 32'd12, target[63:32], 4'hf);
        check_flag("timer_irq before compare point", timer_irq, 1'b0);
        while (!timer_irq && (cycle_count - t0) <= 60 * TIMER_DIV) begin
            @(negedge clk);
        end
        if (!timer_irq) begin
            errors++;
            $display("timer_irq did not rise within %0d cycles of the mtime read",
                     60 * TIMER_DIV);
        end else begin
            // earliest legal rise is 49 prescaler periods after the read returns
            check_flag("timer_irq not early", (cycle_count - t0) >= 49 * TIMER_DIV, 1'b1);
        end
        bus_write(TIMER_BASE + 32'd12, 32'hffff_ffff, 4'hf);
        bus_write(TIMER_BASE + 32'd8, 32'hffff_ffff, 4'hf);
        @(negedge clk);
        check_flag("timer_irq after clear", timer_irq, 1'b0);

        repeat (4) @(negedge clk);
        print_counts();
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, sequence did not complete",
                 WATCHDOG_CYCLES);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- logic/soc_top.sv
/*
 * subsystem top level
 *   host bus port, decoder, ram, uart and timer
 */
module soc_top (
    input  logic           clk,
    input  logic           resetn,
    input  logic           bus_valid,
    input  soc_pkg::addr_t bus_addr,
    input  soc_pkg::data_t bus_wdata,
    input  soc_pkg::strb_t bus_wstrb,
    output soc_pkg::data_t bus_rdata,
    output logic           bus_ready,
    output logic           fault,
    output logic           timer_irq,
    output logic           uart_tx_out,
    input  logic           uart_rx_in
);

    mem_bus_if host_bus ();
    mem_bus_if ram_bus ();
    mem_bus_if uart_bus ();
    mem_bus_if timer_bus ();

    // host port onto the internal bus
    assign host_bus.valid = bus_valid;
    assign host_bus.addr  = bus_addr;
    assign host_bus.wdata = bus_wdata;
    assign host_bus.wstrb = bus_wstrb;
    assign bus_rdata      = host_bus.rdata;
    assign bus_ready      = host_bus.ready;

    bus_decoder u_decoder (
        .clk      (clk),
        .resetn   (resetn),
        .host     (host_bus.slave),
        .ram_bus  (ram_bus.master),
        .uart_bus (uart_bus.master),
        .timer_bus(timer_bus.master),
        .fault    (fault)
    );

    word_ram u_ram (
        .clk   (clk),
        .resetn(resetn),
        .bus   (ram_bus.slave)
    );

    uart_regs u_uart (
        .clk   (clk),
        .resetn(resetn),
        .bus   (uart_bus.slave),
        .tx_out(uart_tx_out),
        .rx_in (uart_rx_in)
    );

    core_timer u_timer (
        .clk      (clk),
        .resetn   (resetn),
        .bus      (timer_bus.slave),
        .timer_irq(timer_irq)
    );

endmodule

//--- logic/core_timer.sv
/*
 * machine timer
 *   prescaled 64-bit mtime, 64-bit mtimecmp written in halves
 *   registered timer interrupt
 */
module core_timer (
    input  logic     clk,
    input  logic     resetn,
    mem_bus_if.slave bus,
    output logic     timer_irq
);
    import soc_pkg::*;

    logic [63:0]            mtime;
    logic [63:0]            mtimecmp;
    logic [TIMER_DIV_W-1:0] div_cnt;
    logic                   req;
    logic                   wr;

    assign req = bus.valid && !bus.ready;
    assign wr  = |bus.wstrb;

    ////////////////////////////////////////////////////////////
    // prescaler, mtime ticks every TIMER_DIV clocks
    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_cnt <= '0;
            mtime   <= '0;
        end else if (div_cnt == TIMER_DIV_W'(TIMER_DIV - 1)) begin
            div_cnt <= '0;
            mtime   <= mtime + 64'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // compare register, all ones keeps the interrupt off
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mtimecmp <= '1;
        end else if (req && wr) begin
            case (bus.addr[3:2])
                2'd2:    mtimecmp[31:0]  <= bus.wdata;
                2'd3:    mtimecmp[63:32] <= bus.wdata;
                default: mtimecmp        <= mtimecmp;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // bus response
    always_ff @(posedge clk) begin
        if (!resetn) begin
            bus.ready <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            bus.ready <= req;
            timer_irq <= mtime >= mtimecmp;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (bus.addr[3:2])
                2'd0:    bus.rdata <= data_t'(mtime[31:0]);
                2'd1:    bus.rdata <= data_t'(mtime[63:32]);
                2'd2:    bus.rdata <= data_t'(mtimecmp[31:0]);
                default: bus.rdata <= data_t'(mtimecmp[63:32]);
            endcase
        end
    end

endmodule

//--- logic/uart_regs.sv
/*
 * uart register block
 *   tx, rx and line-status registers on the bus
 *   transmitter and receiver instances
 */
module uart_regs (
    input  logic     clk,
    input  logic     resetn,
    mem_bus_if.slave bus,
    output logic     tx_out,
    input  logic     rx_in
);
    import soc_pkg::*;

    logic  req;
    logic  wr;
    logic  tx_sel;
    logic  rx_sel;
    logic  lsr_sel;
    logic  respond;
    logic  tx_start;
    logic  tx_idle;
    logic  rx_pop;
    logic  byte_waiting;
    byte_t rx_byte;

    assign req     = bus.valid && !bus.ready;
    assign wr      = |bus.wstrb;
    assign tx_sel  = bus.addr[3:2] == UART_TX_ADDR[3:2];
    assign rx_sel  = bus.addr[3:2] == UART_RX_ADDR[3:2];
    assign lsr_sel = bus.addr[3:2] == UART_LSR_ADDR[3:2];

    // a tx write is held off until the transmitter is free
    assign tx_start = req && wr && tx_sel && tx_idle;
    assign respond  = req && !(wr && tx_sel && !tx_idle);
    assign rx_pop   = req && !wr && rx_sel;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= respond;
        end
    end

    // read data, tx and writes read back zero
    always_ff @(posedge clk) begin
        if (respond) begin
            if (wr) begin
                bus.rdata <= '0;
            end else if (rx_sel) begin
                bus.rdata <= data_t'(rx_byte);
            end else if (lsr_sel) begin
                bus.rdata <= data_t'({tx_idle, 4'b0000, byte_waiting});
            end else begin
                bus.rdata <= '0;
            end
        end
    end

    uart_tx u_tx (
        .clk    (clk),
        .resetn (resetn),
        .start  (tx_start),
        .tx_byte(bus.wdata[7:0]),
        .tx_out (tx_out),
        .idle   (tx_idle)
    );

    uart_rx u_rx (
        .clk         (clk),
        .resetn      (resetn),
        .rx_in       (rx_in),
        .pop         (rx_pop),
        .rx_byte     (rx_byte),
        .byte_waiting(byte_waiting)
    );

    // transmitter goes busy right after a start, and no second start follows
    assert property (@(posedge clk) disable iff (!resetn)
        tx_start |=> (!tx_idle && !tx_start));

endmodule

//--- logic/uart_rx.sv
/*
 * uart receiver
 *   two-flop input synchroniser, start detect, mid-bit sampling
 *   one-byte holding register with a waiting flag
 */
module uart_rx (
    input  logic           clk,
    input  logic           resetn,
    input  logic           rx_in,
    input  logic           pop,
    output soc_pkg::byte_t rx_byte,
    output logic           byte_waiting
);
    import soc_pkg::*;

    rx_state_e             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [BAUD_CNT_W-1:0] clk_cnt;
    logic [2:0]            bit_cnt;
    byte_t                 shift;
    logic                  half_end;
    logic                  bit_end;

    assign half_end = clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);
    assign bit_end  = clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);

    // line idles high
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (state == rx_stop && bit_end) begin
            rx_byte <= shift;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= rx_idle;
            clk_cnt      <= '0;
            bit_cnt      <= '0;
            byte_waiting <= 1'b0;
        end else begin
            if (pop) begin
                byte_waiting <= 1'b0;
            end
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // glitch shorter than half a bit goes back to idle
                    if (half_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    if (bit_end) begin
                        state        <= rx_idle;
                        byte_waiting <= 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

//--- logic/uart_tx.sv
/*
 * uart transmitter
 *   start bit, 8 data bits lsb first, one stop bit
 */
module uart_tx (
    input  logic           clk,
    input  logic           resetn,
    input  logic           start,
    input  soc_pkg::byte_t tx_byte,
    output logic           tx_out,
    output logic           idle
);
    import soc_pkg::*;

    tx_state_e             state;
    logic [BAUD_CNT_W-1:0] clk_cnt;
    logic [2:0]            bit_cnt;
    byte_t                 shift;
    logic                  bit_end;

    assign bit_end = clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);
    assign idle    = state == tx_idle;

    // character shifts out from the bottom
    always_ff @(posedge clk) begin
        if (idle && start) begin
            shift <= tx_byte;
        end else if (state == tx_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= tx_idle;
            tx_out  <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            clk_cnt <= (idle || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                tx_idle: begin
                    if (start) begin
                        state  <= tx_start;
                        tx_out <= 1'b0;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        state   <= tx_data;
                        tx_out  <= shift[0];
                        bit_cnt <= '0;
                    end
                end
                tx_data: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            state  <= tx_stop;
                            tx_out <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_out  <= shift[1];
                        end
                    end
                end
                tx_stop: begin
                    if (bit_end) begin
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

//--- logic/word_ram.sv
/*
 * single-port word ram
 *   byte write strobes, registered read data and ready
 */
module word_ram (
    input  logic     clk,
    input  logic     resetn,
    mem_bus_if.slave bus
);
    import soc_pkg::*;

    data_t      mem [RAM_WORDS];
    ram_index_t index;
    logic       req;

    assign index = bus.addr[RAM_INDEX_W+1:2];

    // one response per request
    assign req = bus.valid && !bus.ready;

    // storage with per-byte write enables
    always_ff @(posedge clk) begin
        if (req) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wstrb[b]) begin
                    mem[index][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
            bus.rdata <= mem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= req;
        end
    end

endmodule

//--- logic/bus_decoder.sv
/*
 * bus interconnect
 *   address decode and request steering to ram, uart and timer
 *   response multiplexing back to the host
 *   local frequency register and fault response for unmapped addresses
 */
module bus_decoder (
    input  logic      clk,
    input  logic      resetn,
    mem_bus_if.slave  host,
    mem_bus_if.master ram_bus,
    mem_bus_if.master uart_bus,
    mem_bus_if.master timer_bus,
    output logic      fault
);
    import soc_pkg::*;

    slave_sel_e sel;
    logic       local_req;
    logic       local_ready;

    // address classification
    always_comb begin
        if (!host.valid) begin
            sel = sel_none;
        end else if (host.addr < RAM_END) begin
            sel = sel_ram;
        end else if (host.addr == UART_TX_ADDR || host.addr == UART_RX_ADDR ||
                     host.addr == UART_LSR_ADDR) begin
            sel = sel_uart;
        end else if (host.addr[31:4] == TIMER_BASE[31:4]) begin
            sel = sel_timer;
        end else if (host.addr == FREQ_ADDR) begin
            sel = sel_freq;
        end else begin
            sel = sel_fault;
        end
    end

    ////////////////////////////////////////////////////////////
    // request steering, valid drops once the response is back
    assign ram_bus.valid   = (sel == sel_ram) && !host.ready;
    assign uart_bus.valid  = (sel == sel_uart) && !host.ready;
    assign timer_bus.valid = (sel == sel_timer) && !host.ready;

    assign ram_bus.addr    = host.addr;
    assign ram_bus.wdata   = host.wdata;
    assign ram_bus.wstrb   = host.wstrb;
    assign uart_bus.addr   = host.addr;
    assign uart_bus.wdata  = host.wdata;
    assign uart_bus.wstrb  = host.wstrb;
    assign timer_bus.addr  = host.addr;
    assign timer_bus.wdata = host.wdata;
    assign timer_bus.wstrb = host.wstrb;

    // frequency and fault answer one cycle after the request
    assign local_req = (sel == sel_freq || sel == sel_fault) && !local_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            local_ready <= 1'b0;
        end else begin
            local_ready <= local_req;
        end
    end

    ////////////////////////////////////////////////////////////
    // response mux, no added latency
    always_comb begin
        host.ready = 1'b0;
        host.rdata = '0;
        fault      = 1'b0;
        case (sel)
            sel_ram: begin
                host.ready = ram_bus.ready;
                host.rdata = ram_bus.rdata;
            end
            sel_uart: begin
                host.ready = uart_bus.ready;
                host.rdata = uart_bus.rdata;
            end
            sel_timer: begin
                host.ready = timer_bus.ready;
                host.rdata = timer_bus.rdata;
            end
            sel_freq: begin
                host.ready = local_ready;
                host.rdata = SYS_CLK_HZ;
            end
            sel_fault: begin
                host.ready = local_ready;
                fault      = local_ready;
            end
            default: begin
                host.ready = 1'b0;
            end
        endcase
    end

    // only one responder at a time
    assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({ram_bus.ready, uart_bus.ready, timer_bus.ready, local_ready}));

    // every response follows a request from the previous cycle
    assert property (@(posedge clk) disable iff (!resetn)
        host.ready |-> $past(host.valid));

endmodule

//--- logic/mem_bus_if.sv
/*
 * valid/ready memory bus
 *   request fields from the master, read data and ready from the slave
 *   master and slave modports
 */
interface mem_bus_if;
    import soc_pkg::*;

    // request side
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;

    // response side, ready is a single-cycle pulse
    data_t rdata;
    logic  ready;

    modport master (
        output valid,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  ready
    );

    modport slave (
        input  valid,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output ready
    );

endinterface

//--- logic/soc_pkg.sv
/*
 * shared definitions for the peripheral subsystem
 *   vector types for addresses, data, strobes and characters
 *   address map, uart baud and timer prescaler constants
 *   decoder and uart state enums
 */
package soc_pkg;

    // vector types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  byte_t;

    ////////////////////////////////////////////////////////////
    // word ram, 4 KiB at the bottom of the map
    localparam int    RAM_WORDS   = 1024;
    localparam int    RAM_INDEX_W = $clog2(RAM_WORDS);
    localparam addr_t RAM_END     = addr_t'(RAM_WORDS * 4);

    typedef logic [RAM_INDEX_W-1:0] ram_index_t;

    ////////////////////////////////////////////////////////////
    // uart registers and bit timing
    localparam addr_t UART_TX_ADDR  = 32'h1000_0000;
    localparam addr_t UART_RX_ADDR  = 32'h1000_0004;
    localparam addr_t UART_LSR_ADDR = 32'h1000_0008;
    localparam int    CLKS_PER_BIT  = 8;
    localparam int    BAUD_CNT_W    = $clog2(CLKS_PER_BIT);

    ////////////////////////////////////////////////////////////
    // machine timer, mtime at +0/+4 and mtimecmp at +8/+12
    localparam addr_t TIMER_BASE  = 32'h1100_0000;
    localparam int    TIMER_DIV   = 4;
    localparam int    TIMER_DIV_W = $clog2(TIMER_DIV);

    // read-only clock frequency register
    localparam addr_t FREQ_ADDR  = 32'h1200_0000;
    localparam data_t SYS_CLK_HZ = 32'd25_000_000;

    // decoder target
    typedef enum logic [2:0] {
        sel_none,
        sel_ram,
        sel_uart,
        sel_timer,
        sel_freq,
        sel_fault
    } slave_sel_e;

    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage
